// File: logic/mapper_pkg.sv
package mapper_pkg;

	// --------------------------------------------------------------------------
	// widths of the bus and of the mapper address space
	// --------------------------------------------------------------------------

	localparam int ADDR_WIDTH = 16;
	localparam int DATA_WIDTH = 8;

	// the cpu space is split into four pages by the top two address bits
	localparam int PAGE_WIDTH = 2;
	localparam int PAGE_COUNT = 1 << PAGE_WIDTH;
	localparam int OFFSET_WIDTH = ADDR_WIDTH - PAGE_WIDTH;
	localparam int PAGE_SIZE = 1 << OFFSET_WIDTH;

	// eight segments of 16 KB give the 128 KB of physical ram
	localparam int SEGMENT_WIDTH = 3;
	localparam int SEGMENT_COUNT = 1 << SEGMENT_WIDTH;
	localparam int PHYS_WIDTH = SEGMENT_WIDTH + OFFSET_WIDTH;

	typedef logic [ADDR_WIDTH-1:0] bus_addr_t;
	typedef logic [DATA_WIDTH-1:0] byte_t;
	typedef logic [PAGE_WIDTH-1:0] page_t;
	typedef logic [OFFSET_WIDTH-1:0] offset_t;
	typedef logic [SEGMENT_WIDTH-1:0] segment_t;
	typedef logic [PHYS_WIDTH-1:0] phys_addr_t;

	// one segment number per page, indexed by the page number
	typedef segment_t [PAGE_COUNT-1:0] segment_table_t;

	// the mapper ports are 0xFC to 0xFF, the low two bits select the page
	localparam byte_t MAPPER_PORT_BASE = 8'hFC;

	// page 0 starts on segment 3 and page 3 on segment 0
	localparam segment_table_t RESET_SEGMENT = {3'd0, 3'd1, 3'd2, 3'd3};

	// --------------------------------------------------------------------------
	// bundles passed between the stages
	// --------------------------------------------------------------------------

	// raw msx-50bus strobes as they arrive at the top
	typedef struct packed {
		bus_addr_t address;
		byte_t write_data;
		logic read;
		logic write;
		logic io;
		logic memory;
	} bus_req_t;

	// decoded memory access, read and write never both high
	typedef struct packed {
		logic read;
		logic write;
		page_t page;
		offset_t offset;
		byte_t data;
	} mem_cmd_t;

	// decoded access to one of the four mapper ports
	typedef struct packed {
		logic read;
		logic write;
		page_t port;
		byte_t data;
	} io_cmd_t;

endpackage

// File: logic/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
	input mapper_pkg::bus_req_t bus,
	output mapper_pkg::mem_cmd_t mem_cmd,
	output mapper_pkg::io_cmd_t io_cmd,
	output logic io_hit,
	output logic mem_hit
);

	// --------------------------------------------------------------------------
	// address split
	// --------------------------------------------------------------------------

	// the low address byte is the i/o port number
	mapper_pkg::byte_t port_byte;

	// page and offset of a memory access
	mapper_pkg::page_t page;
	mapper_pkg::offset_t offset;

	always_comb begin
		port_byte = bus.address[mapper_pkg::DATA_WIDTH-1:0];
		page = bus.address[mapper_pkg::ADDR_WIDTH-1 -: mapper_pkg::PAGE_WIDTH];
		offset = bus.address[mapper_pkg::OFFSET_WIDTH-1:0];
	end

	// --------------------------------------------------------------------------
	// chip selects
	// --------------------------------------------------------------------------

	// the mapper owns the whole memory space, so every memory cycle is ours
	assign mem_hit = bus.memory;

	// the four ports share their upper six bits with the base port,
	// the bottom two bits then name the page whose register is addressed
	always_comb begin
		io_hit = bus.io &&
			(port_byte[mapper_pkg::DATA_WIDTH-1:mapper_pkg::PAGE_WIDTH] ==
			mapper_pkg::MAPPER_PORT_BASE[mapper_pkg::DATA_WIDTH-1:mapper_pkg::PAGE_WIDTH]);
	end

	// --------------------------------------------------------------------------
	// memory command
	// --------------------------------------------------------------------------

	// read wins when the bus shows both strobes at once, so a write
	// is only passed on when no read is present
	always_comb begin
		mem_cmd.read = mem_hit && bus.read;
		mem_cmd.write = mem_hit && bus.write && !bus.read;
		mem_cmd.page = page;
		mem_cmd.offset = offset;
		mem_cmd.data = bus.write_data;
	end

	// --------------------------------------------------------------------------
	// i/o command
	// --------------------------------------------------------------------------

	// same priority rule as the memory side,
	// ports outside the mapper range never produce a command
	always_comb begin
		io_cmd.read = io_hit && bus.read;
		io_cmd.write = io_hit && bus.write && !bus.read;
		io_cmd.port = port_byte[mapper_pkg::PAGE_WIDTH-1:0];
		io_cmd.data = bus.write_data;
	end

endmodule

// File: logic/segment_registers.sv
`timescale 1ns/1ps

module segment_registers (
	input logic clk,
	input logic n_reset,
	input mapper_pkg::io_cmd_t io_cmd,
	output mapper_pkg::segment_table_t segment_table,
	output mapper_pkg::byte_t io_read_data
);

	// --------------------------------------------------------------------------
	// segment registers
	// --------------------------------------------------------------------------

	// one register per page, entry 0 serves port 0xFC
	mapper_pkg::segment_table_t ff_segment;

	// the segment chosen for the addressed page
	mapper_pkg::segment_t selected;

	// only the low bits of the written byte fit a segment number,
	// the upper bits are simply dropped
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_segment <= mapper_pkg::RESET_SEGMENT;
		end
		else if (io_cmd.write) begin
			ff_segment[io_cmd.port] <= io_cmd.data[mapper_pkg::SEGMENT_WIDTH-1:0];
		end
	end

	// the memory stage sees a new value from the edge that wrote it,
	// so an access in the following cycle already uses the new segment
	assign segment_table = ff_segment;

	// --------------------------------------------------------------------------
	// read-back
	// --------------------------------------------------------------------------

	// the port read is combinational here
	// and gets registered in the response stage
	always_comb begin
		selected = ff_segment[io_cmd.port];
		io_read_data = {{(mapper_pkg::DATA_WIDTH - mapper_pkg::SEGMENT_WIDTH){1'b0}},
			selected};
	end

endmodule

// File: logic/mapper_memory.sv
`timescale 1ns/1ps

module mapper_memory (
	input logic clk,
	input mapper_pkg::mem_cmd_t mem_cmd,
	input mapper_pkg::segment_table_t segment_table,
	output mapper_pkg::byte_t mem_read_data
);

	// eight segments of one page each
	localparam int RAM_DEPTH = mapper_pkg::SEGMENT_COUNT * mapper_pkg::PAGE_SIZE;

	// --------------------------------------------------------------------------
	// address mapping
	// --------------------------------------------------------------------------

	// segment currently mapped into the addressed page
	mapper_pkg::segment_t segment;

	// segment on top, page offset below
	mapper_pkg::phys_addr_t phys_addr;

	always_comb begin
		segment = segment_table[mem_cmd.page];
		phys_addr = {segment, mem_cmd.offset};
	end

	// --------------------------------------------------------------------------
	// ram array
	// --------------------------------------------------------------------------

	mapper_pkg::byte_t ff_ram [RAM_DEPTH];

	// read data stays put until the next read, the response stage
	// only looks at it in the cycle right after a read
	mapper_pkg::byte_t ff_read_data;

	// the decoder never raises read and write together,
	// so one port of the array is enough
	always_ff @(posedge clk) begin
		if (mem_cmd.read) begin
			ff_read_data <= ff_ram[phys_addr];
		end
		else if (mem_cmd.write) begin
			ff_ram[phys_addr] <= mem_cmd.data;
		end
	end

	assign mem_read_data = ff_read_data;

endmodule

// File: logic/bus_response.sv
`timescale 1ns/1ps

module bus_response (
	input logic clk,
	input logic n_reset,
	input mapper_pkg::io_cmd_t io_cmd,
	input mapper_pkg::mem_cmd_t mem_cmd,
	input logic io_hit,
	input logic mem_hit,
	input mapper_pkg::byte_t io_read_data,
	input mapper_pkg::byte_t mem_read_data,
	output logic bus_read_ready,
	output logic bus_io_cs,
	output logic bus_memory_cs,
	output mapper_pkg::byte_t bus_read_data
);

	// --------------------------------------------------------------------------
	// read pipeline register
	// --------------------------------------------------------------------------

	// high for exactly the cycle after a sampled read strobe
	logic ff_read_ready;

	// set when that read went to a mapper port rather than to ram
	logic ff_from_io;

	// port value captured at the read edge
	mapper_pkg::byte_t ff_io_data;

	// a read every cycle keeps ready high, each cycle then
	// carries the answer to the strobe one edge earlier
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_read_ready <= 1'b0;
			ff_from_io <= 1'b0;
		end
		else begin
			ff_read_ready <= io_cmd.read || mem_cmd.read;
			ff_from_io <= io_cmd.read;
		end
	end

	always_ff @(posedge clk) begin
		if (io_cmd.read) begin
			ff_io_data <= io_read_data;
		end
	end

	// --------------------------------------------------------------------------
	// outputs
	// --------------------------------------------------------------------------

	// data is forced to zero whenever no answer is due
	always_comb begin
		if (!ff_read_ready) begin
			bus_read_data = '0;
		end
		else if (ff_from_io) begin
			bus_read_data = ff_io_data;
		end
		else begin
			bus_read_data = mem_read_data;
		end
	end

	assign bus_read_ready = ff_read_ready;

	// selects follow the current bus inputs with no delay
	assign bus_io_cs = io_hit;
	assign bus_memory_cs = mem_hit;

endmodule

// File: logic/mapper_ram_top.sv
`timescale 1ns/1ps

module mapper_ram_top (
	input logic clk,
	input logic n_reset,
	// msx-50bus
	input mapper_pkg::bus_addr_t bus_address,
	input mapper_pkg::byte_t bus_write_data,
	input logic bus_read,
	input logic bus_write,
	input logic bus_io,
	input logic bus_memory,
	output logic bus_io_cs,
	output logic bus_memory_cs,
	output logic bus_read_ready,
	output mapper_pkg::byte_t bus_read_data
);

	// --------------------------------------------------------------------------
	// interconnect
	// --------------------------------------------------------------------------

	mapper_pkg::bus_req_t bus_req;
	mapper_pkg::mem_cmd_t mem_cmd;
	mapper_pkg::io_cmd_t io_cmd;
	mapper_pkg::segment_table_t segment_table;
	mapper_pkg::byte_t io_read_data;
	mapper_pkg::byte_t mem_read_data;
	logic io_hit;
	logic mem_hit;

	// raw strobes gathered into one bundle for the decoder
	always_comb begin
		bus_req.address = bus_address;
		bus_req.write_data = bus_write_data;
		bus_req.read = bus_read;
		bus_req.write = bus_write;
		bus_req.io = bus_io;
		bus_req.memory = bus_memory;
	end

	// --------------------------------------------------------------------------
	// stages
	// --------------------------------------------------------------------------

	bus_decoder decoder_i (
		.bus(bus_req),
		.mem_cmd(mem_cmd),
		.io_cmd(io_cmd),
		.io_hit(io_hit),
		.mem_hit(mem_hit)
	);

	segment_registers segment_i (
		.clk(clk),
		.n_reset(n_reset),
		.io_cmd(io_cmd),
		.segment_table(segment_table),
		.io_read_data(io_read_data)
	);

	mapper_memory memory_i (
		.clk(clk),
		.mem_cmd(mem_cmd),
		.segment_table(segment_table),
		.mem_read_data(mem_read_data)
	);

	bus_response response_i (
		.clk(clk),
		.n_reset(n_reset),
		.io_cmd(io_cmd),
		.mem_cmd(mem_cmd),
		.io_hit(io_hit),
		.mem_hit(mem_hit),
		.io_read_data(io_read_data),
		.mem_read_data(mem_read_data),
		.bus_read_ready(bus_read_ready),
		.bus_io_cs(bus_io_cs),
		.bus_memory_cs(bus_memory_cs),
		.bus_read_data(bus_read_data)
	);

endmodule

// File: tb/tb_mapper_tasks.svh
`ifndef TB_MAPPER_TASKS_SVH
`define TB_MAPPER_TASKS_SVH

// --------------------------------------------------------------------------
// reference model
// --------------------------------------------------------------------------

// only the four ports 0xFC to 0xFF belong to the mapper
function automatic logic is_mapper_port(mapper_pkg::byte_t port);
	return port >= 8'hFC;
endfunction

// the page in the top two address bits is replaced by its segment
function automatic mapper_pkg::phys_addr_t physical_of(mapper_pkg::bus_addr_t address);
	return {model_seg[address[15:14]], address[13:0]};
endfunction

// a port read gives the segment number with the upper bits cleared
function automatic mapper_pkg::byte_t expected_read(logic io, mapper_pkg::bus_addr_t address);
	if (io) begin
		return {5'b00000, model_seg[address[1:0]]};
	end
	return model_mem[physical_of(address)];
endfunction

// --------------------------------------------------------------------------
// compare tasks
// --------------------------------------------------------------------------

task automatic check_byte(string what, mapper_pkg::byte_t expected,
		mapper_pkg::byte_t actual);
	if (actual !== expected) begin
		$display("Error in %s: %s expected 0x%02h, actual 0x%02h",
			test_name, what, expected, actual);
		stop_with_failure();
	end
endtask

task automatic check_flag(string what, logic expected, logic actual);
	if (actual !== expected) begin
		$display("Error in %s: %s expected %b, actual %b", test_name, what, expected, actual);
		stop_with_failure();
	end
endtask

// --------------------------------------------------------------------------
// bus cycles
// --------------------------------------------------------------------------

// one cycle of strobes, left in place until the next call drives new ones
task automatic drive_bus(mapper_pkg::bus_addr_t address, mapper_pkg::byte_t data,
		logic read, logic write, logic io, logic memory);
	@(negedge clk);
	bus_address = address;
	bus_write_data = data;
	bus_read = read;
	bus_write = write;
	bus_io = io;
	bus_memory = memory;
	// an answer is owed for every read to ram or to a mapper port
	read_due = read && (memory || (io && is_mapper_port(address[7:0])));
	// the selects follow the inputs without a clock, half a phase is plenty
	#5;
	check_flag("bus_io_cs", io && is_mapper_port(address[7:0]), bus_io_cs);
	check_flag("bus_memory_cs", memory, bus_memory_cs);
endtask

task automatic bus_idle();
	drive_bus(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
endtask

task automatic io_write(mapper_pkg::bus_addr_t address, mapper_pkg::byte_t data);
	drive_bus(address, data, 1'b0, 1'b1, 1'b1, 1'b0);
	// a segment register keeps only the low three bits of the byte
	if (is_mapper_port(address[7:0])) begin
		model_seg[address[1:0]] = data[2:0];
	end
endtask

task automatic io_read(mapper_pkg::bus_addr_t address);
	drive_bus(address, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
	if (is_mapper_port(address[7:0])) begin
		expect_q.push_back(expected_read(1'b1, address));
	end
endtask

task automatic mem_write(mapper_pkg::bus_addr_t address, mapper_pkg::byte_t data);
	mapper_pkg::phys_addr_t phys;
	drive_bus(address, data, 1'b0, 1'b1, 1'b0, 1'b1);
	phys = physical_of(address);
	model_mem[phys] = data;
	model_written[phys] = 1'b1;
	written_q.push_back(phys);
endtask

task automatic mem_read(mapper_pkg::bus_addr_t address);
	// ram holds no defined value before its first write
	if (!model_written[physical_of(address)]) begin
		$display("the stimulus tried to read ram at 0x%04h before writing it", address);
		stop_with_failure();
	end
	drive_bus(address, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1);
	expect_q.push_back(expected_read(1'b0, address));
endtask

`endif

// File: tb/tb_mapper_ram.sv
`timescale 1ns/1ps

module tb_mapper_ram;

	localparam int CLOCK_PERIOD_NS = 20;
	localparam int RESET_CYCLES = 16;
	localparam int DIRECTED_OPS = 200;
	localparam int RANDOM_OPS = 2000;
	localparam int RANDOM_SEED = 66156;
	// three cycles for each operation, then twice that for slack
	localparam int WATCHDOG_NS =
		(RESET_CYCLES + DIRECTED_OPS + RANDOM_OPS) * 3 * CLOCK_PERIOD_NS * 2;

	logic clk = 1'b0;
	logic n_reset;
	mapper_pkg::bus_addr_t bus_address;
	mapper_pkg::byte_t bus_write_data;
	logic bus_read;
	logic bus_write;
	logic bus_io;
	logic bus_memory;
	logic bus_io_cs;
	logic bus_memory_cs;
	logic bus_read_ready;
	mapper_pkg::byte_t bus_read_data;

	// the model keeps one segment per page and the whole 128 KB of ram
	mapper_pkg::segment_t model_seg [4];
	mapper_pkg::byte_t model_mem [mapper_pkg::SEGMENT_COUNT * mapper_pkg::PAGE_SIZE];
	bit model_written [mapper_pkg::SEGMENT_COUNT * mapper_pkg::PAGE_SIZE];
	mapper_pkg::phys_addr_t written_q [$];

	// bytes owed by the DUT with the oldest read first
	mapper_pkg::byte_t expect_q [$];
	logic read_due;
	string test_name;

	always #(CLOCK_PERIOD_NS / 2) clk = ~clk;

	mapper_ram_top dut_i (
		.clk(clk),
		.n_reset(n_reset),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_io(bus_io),
		.bus_memory(bus_memory),
		.bus_io_cs(bus_io_cs),
		.bus_memory_cs(bus_memory_cs),
		.bus_read_ready(bus_read_ready),
		.bus_read_data(bus_read_data)
	);

	task automatic stop_with_failure();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	`include "tb_mapper_tasks.svh"

	// ----------------------------------------------------------------------
	// stimulus helpers
	// ----------------------------------------------------------------------

	// offsets 0x0000, 0x1555, 0x2AAA and 0x3FFF hit both ends of a page
	function automatic mapper_pkg::bus_addr_t trip_address(int p, int k);
		return {p[1:0], k[13:0] * 14'h1555};
	endfunction

	task automatic page_round_trip(mapper_pkg::byte_t salt);
		for (int p = 0; p < 4; p++) begin
			for (int k = 0; k < 4; k++) begin
				mem_write(trip_address(p, k), {p[1:0], k[1:0], 4'h5} ^ salt);
			end
		end
		for (int p = 0; p < 4; p++) begin
			for (int k = 0; k < 4; k++) begin
				mem_read(trip_address(p, k));
			end
		end
		bus_idle();
	endtask

	// reads only go to ram locations that the model has seen written
	task automatic random_mix();
		int unsigned rnd;
		int unsigned pick;
		int page_found;
		mapper_pkg::bus_addr_t address;
		mapper_pkg::phys_addr_t phys;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			rnd = $urandom();
			address = rnd[15:0];
			case (rnd[31:30])
				2'd0: io_write({address[15:8], 6'b111111, address[1:0]}, rnd[23:16]);
				2'd1: mem_write(address, rnd[23:16]);
				default: begin
					if (rnd[29]) begin
						io_read({address[15:8], 6'b111111, address[1:0]});
					end
					else begin
						pick = $urandom() % written_q.size();
						phys = written_q[pick];
						page_found = -1;
						for (int p = 0; p < 4; p++) begin
							if (model_seg[p] == phys[16:14]) begin
								page_found = p;
							end
						end
						// no page shows that segment yet, so map it in first
						if (page_found < 0) begin
							page_found = int'(address[15:14]);
							io_write({8'h00, 6'b111111, address[15:14]},
								{5'b00000, phys[16:14]});
						end
						mem_read({page_found[1:0], phys[13:0]});
					end
				end
			endcase
			// skipping the idle cycle leaves reads back to back
			if (rnd[28]) begin
				bus_idle();
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// checking and watchdog
	// ----------------------------------------------------------------------

	// the strobe seen at one rising edge is answered in the cycle after it
	initial begin
		logic due;
		mapper_pkg::byte_t expected;
		wait (n_reset === 1'b1);
		forever begin
			@(posedge clk);
			due = read_due;
			@(negedge clk);
			if (due) begin
				check_flag("bus_read_ready", 1'b1, bus_read_ready);
				expected = expect_q.pop_front();
				check_byte("bus_read_data", expected, bus_read_data);
			end
			else begin
				check_flag("bus_read_ready", 1'b0, bus_read_ready);
				check_byte("bus_read_data outside a pulse", 8'h00, bus_read_data);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
		stop_with_failure();
	end

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------

	initial begin
		void'($urandom(RANDOM_SEED));
		n_reset = 1'b0;
		bus_address = 16'h0000;
		bus_write_data = 8'h00;
		bus_read = 1'b0;
		bus_write = 1'b0;
		bus_io = 1'b0;
		bus_memory = 1'b0;
		read_due = 1'b0;
		test_name = "reset";
		// page 0 starts on segment 3 and page 3 on segment 0
		model_seg[0] = 3'd3;
		model_seg[1] = 3'd2;
		model_seg[2] = 3'd1;
		model_seg[3] = 3'd0;
		repeat (RESET_CYCLES) @(negedge clk);
		n_reset = 1'b1;

		test_name = "reset values";
		for (int p = 0; p < 4; p++) begin
			io_read({8'h00, 6'b111111, p[1:0]});
			bus_idle();
		end

		// first pass on the reset mapping, then segments 4 to 7
		test_name = "page round trip";
		page_round_trip(8'h00);
		for (int p = 0; p < 4; p++) begin
			io_write({8'h00, 6'b111111, p[1:0]}, {5'b10101, 1'b1, p[1:0]});
		end
		for (int p = 0; p < 4; p++) begin
			io_read({8'h00, 6'b111111, p[1:0]});
		end
		page_round_trip(8'hC3);

		test_name = "shared segment";
		io_write(16'h00FD, 8'h05);
		io_write(16'h00FE, 8'h05);
		mem_write(16'h4123, 8'hA5);
		mem_read(16'h8123);
		io_write(16'h00FF, 8'h06);
		mem_write(16'hC123, 8'h3C);
		io_write(16'h00FE, 8'h06);
		mem_read(16'h8123);
		mem_read(16'h4123);
		bus_idle();

		// misses must leave the segment registers as they were
		test_name = "foreign ports";
		io_write(16'h00FB, 8'h07);
		io_write(16'h0000, 8'h07);
		io_write(16'hFC00, 8'h07);
		io_read(16'h00FB);
		io_read(16'h007F);
		bus_idle();
		for (int p = 0; p < 4; p++) begin
			io_read({8'h5A, 6'b111111, p[1:0]});
		end
		bus_idle();

		test_name = "back to back reads";
		mem_read(trip_address(0, 1));
		mem_read(trip_address(3, 2));
		io_read(16'h00FE);
		mem_read(trip_address(1, 3));
		io_read(16'h00FC);
		io_read(16'h00FD);
		mem_read(trip_address(2, 0));
		bus_idle();

		test_name = "random mix";
		random_mix();
		bus_idle();

		repeat (2) @(negedge clk);
		if (expect_q.size() != 0) begin
			$display("%0d reads never got an answer from the DUT", expect_q.size());
			stop_with_failure();
		end
		else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

// File: sim.f
+incdir+tb
logic/mapper_pkg.sv
logic/bus_decoder.sv
logic/segment_registers.sv
logic/mapper_memory.sv
logic/bus_response.sv
logic/mapper_ram_top.sv
tb/tb_mapper_ram.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and passes only on the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mapper_ram -f sim.f -o tb_mapper_ram \
	|| { echo "verilator build failed"; exit 1; }

sim_output=$(./obj_dir/tb_mapper_ram 2>&1)
echo "$sim_output"

echo "$sim_output" | grep -qx "Simulation PASSED" \
	&& exit 0 \
	|| exit 1
